//--- verilog/calc_consts.svh
`ifndef CALC_CONSTS_SVH
`define CALC_CONSTS_SVH

// datapath width of entry, accumulator and result
`define CALC_WIDTH 16

// cycles a row must stay low before a press counts
`define DEBOUNCE_CYCLES 10

`endif

//--- verilog/calc_pkg.sv
package calc_pkg;

    // operator codes carried from keypad to alu
    typedef enum logic [2:0] {
        op_none = 3'd0,     // no pending op, alu passes b
        op_neg  = 3'd1,     // sign key, never reaches alu
        op_add  = 3'd2,
        op_sub  = 3'd3,
        op_mul  = 3'd4
    } op_t;

    // class of a decoded key
    typedef enum logic [1:0] {
        key_digit = 2'd0,   // 0..9 on key_digit
        key_op    = 2'd1,   // operator on key_op
        key_equal = 2'd2    // equals
    } key_kind_t;

endpackage

//--- verilog/calc_alu.sv
`include "calc_consts.svh"

module calc_alu (
    input  logic signed [`CALC_WIDTH-1:0] a,    // accumulator
    input  logic signed [`CALC_WIDTH-1:0] b,    // entry
    input  calc_pkg::op_t                 op,
    output logic signed [`CALC_WIDTH-1:0] y,
    output logic                          ovf   // exact result out of range
);
    import calc_pkg::*;

    localparam int W = `CALC_WIDTH;

    logic signed [W:0]     sum_w;   // one guard bit
    logic signed [W:0]     diff_w;
    logic signed [2*W-1:0] prod_w;  // full product
    logic [W:0]            prod_hi; // bits that must all match the sign

    assign sum_w   = a + b;
    assign diff_w  = a - b;
    assign prod_w  = a * b;
    assign prod_hi = prod_w[2*W-1:W-1];

    always_comb begin
        case (op)
            op_add: begin
                y   = sum_w[W-1:0];
                ovf = sum_w[W] ^ sum_w[W-1];
            end
            op_sub: begin
                y   = diff_w[W-1:0];
                ovf = diff_w[W] ^ diff_w[W-1];
            end
            op_mul: begin
                y   = prod_w[W-1:0];            // truncated
                ovf = (prod_hi != '0) && (prod_hi != '1);
            end
            default: begin
                y   = b;                        // first operand loads acc
                ovf = 1'b0;
            end
        endcase
    end

endmodule

//--- verilog/keypad_scan.sv
`include "calc_consts.svh"

module keypad_scan (
    input  logic                clk,
    input  logic                nRST,
    input  logic [3:0]          row_in,     // rows, pulled up, low when pressed
    output logic [3:0]          col_out,    // one column driven low at a time
    output logic                read_input, // key waiting for controller
    input  logic                key_read,   // one-cycle ack from controller
    output calc_pkg::key_kind_t key_kind,
    output logic [3:0]          key_digit,
    output calc_pkg::op_t       key_op
);
    import calc_pkg::*;

    localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] DEB_MAX = CNT_W'(`DEBOUNCE_CYCLES);
    localparam logic [3:0] NO_KEY = 4'hE;   // blank position in the matrix

    typedef enum logic [2:0] {
        st_idle, st_scan, st_debounce, st_confirm, st_release
    } state_t;

    state_t state, next_state;

    logic [1:0]       col_idx;      // column currently driven
    logic [CNT_W-1:0] deb_cnt;      // cycles row has stayed low
    logic             row_low;      // any row pulled low
    logic [3:0]       key_idx;      // row*4 + column
    logic             dec_valid;    // key_idx maps to a real key
    key_kind_t        dec_kind;
    logic [3:0]       dec_digit;
    op_t              dec_op;

    // first low row wins, NO_KEY if the row let go
    function automatic logic [3:0] encode_key(input logic [3:0] row, input logic [1:0] col);
        logic [3:0] idx;
        idx = NO_KEY;
        for (int r = 3; r >= 0; r--) begin
            if (!row[r])
                idx = {2'(r), col};
        end
        return idx;
    endfunction

    assign row_low = ~&row_in;
    assign key_idx = encode_key(row_in, col_idx);

    always_comb begin
        col_out = 4'b1111;
        col_out[col_idx] = 1'b0;    // active low column
    end

    always_comb begin
        dec_valid = 1'b1;
        dec_kind  = calc_pkg::key_digit;
        dec_digit = 4'd0;
        dec_op    = op_none;
        case (key_idx)
            4'h0: dec_digit = 4'd1;
            4'h1: dec_digit = 4'd2;
            4'h2: dec_digit = 4'd3;
            4'h4: dec_digit = 4'd4;
            4'h5: dec_digit = 4'd5;
            4'h6: dec_digit = 4'd6;
            4'h8: dec_digit = 4'd7;
            4'h9: dec_digit = 4'd8;
            4'hA: dec_digit = 4'd9;
            4'hD: dec_digit = 4'd0;
            4'h3: begin dec_kind = calc_pkg::key_op; dec_op = op_add; end
            4'h7: begin dec_kind = calc_pkg::key_op; dec_op = op_sub; end
            4'hB: begin dec_kind = calc_pkg::key_op; dec_op = op_mul; end
            4'hF: begin dec_kind = calc_pkg::key_op; dec_op = op_neg; end // sign
            4'hC: dec_kind = key_equal;
            default: dec_valid = 1'b0;  // 14 is not wired to anything
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle:     next_state = st_scan;
            st_scan:     next_state = row_low ? st_debounce : st_scan;
            st_debounce: begin
                if (!row_low)
                    next_state = st_scan;       // bounce, start over
                else if (deb_cnt == DEB_MAX)
                    next_state = st_confirm;
            end
            st_confirm: begin
                if (!read_input && !dec_valid)
                    next_state = st_release;    // blank key, skip handshake
                else if (read_input && key_read)
                    next_state = st_release;
            end
            st_release:  next_state = row_low ? st_release : st_scan;
            default:     next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= st_idle;
            col_idx    <= 2'd0;
            deb_cnt    <= '0;
            read_input <= 1'b0;
        end else begin
            state <= next_state;
            if (state == st_scan && !row_low)
                col_idx <= col_idx + 2'd1;      // wraps 3 -> 0
            if (state == st_debounce && row_low) begin
                if (deb_cnt != DEB_MAX)
                    deb_cnt <= deb_cnt + 1'b1;
            end else begin
                deb_cnt <= '0;
            end
            if (state == st_confirm) begin
                if (!read_input && dec_valid)
                    read_input <= 1'b1;         // high from next cycle
                else if (read_input && key_read)
                    read_input <= 1'b0;
            end
        end
    end

    // key data, held steady while read_input is up
    always_ff @(posedge clk) begin
        if (state == st_confirm && !read_input && dec_valid) begin
            key_kind  <= dec_kind;
            key_digit <= dec_digit;
            key_op    <= dec_op;
        end
    end

endmodule

//--- verilog/calc_control.sv
`include "calc_consts.svh"

module calc_control (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic                          read_input,   // key pending in scanner
    input  calc_pkg::key_kind_t           key_kind,
    input  logic [3:0]                    key_digit,
    input  calc_pkg::op_t                 key_op,
    output logic                          key_read,     // one-cycle ack
    output logic signed [`CALC_WIDTH-1:0] alu_a,
    output logic signed [`CALC_WIDTH-1:0] alu_b,
    output calc_pkg::op_t                 alu_op,
    input  logic signed [`CALC_WIDTH-1:0] alu_y,
    input  logic                          alu_ovf,
    output logic signed [`CALC_WIDTH-1:0] entry_value,
    output logic signed [`CALC_WIDTH-1:0] result,
    output logic                          result_valid,
    output logic                          overflow
);
    import calc_pkg::*;

    localparam int W = `CALC_WIDTH;
    localparam logic signed [W-1:0] TEN = 10;

    logic signed [W-1:0] entry;         // number being typed
    logic signed [W-1:0] acc;           // left operand
    logic signed [W-1:0] entry_digit;   // entry with new digit appended
    op_t                 pend_op;       // operator waiting for right operand
    logic                sticky_ovf;    // overflow seen since last equals
    logic                acked;         // read_input already answered

    // ack only the first cycle of a read_input episode
    assign key_read = read_input && !acked;

    assign alu_a       = acc;
    assign alu_b       = entry;
    assign alu_op      = pend_op;
    assign entry_value = entry;

    assign entry_digit = entry * TEN + W'(key_digit);   // wraps on overflow

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            entry        <= '0;
            acc          <= '0;
            pend_op      <= op_none;
            sticky_ovf   <= 1'b0;
            acked        <= 1'b0;
            result       <= '0;
            result_valid <= 1'b0;
            overflow     <= 1'b0;
        end else begin
            acked        <= read_input;
            result_valid <= 1'b0;                   // pulse only
            if (key_read) begin
                case (key_kind)
                    calc_pkg::key_digit: entry <= entry_digit;
                    calc_pkg::key_op: begin
                        if (key_op == op_neg) begin
                            entry <= -entry;        // sign toggle
                        end else begin
                            acc        <= alu_y;    // fold pending op
                            pend_op    <= key_op;
                            entry      <= '0;
                            sticky_ovf <= sticky_ovf | alu_ovf;
                        end
                    end
                    key_equal: begin
                        result       <= alu_y;
                        acc          <= alu_y;      // chain from result
                        overflow     <= sticky_ovf | alu_ovf;
                        sticky_ovf   <= 1'b0;
                        entry        <= '0;
                        pend_op      <= op_none;
                        result_valid <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- verilog/calculator_top.sv
`include "calc_consts.svh"

module calculator_top (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic [3:0]                    row_in,       // keypad rows
    output logic [3:0]                    col_out,      // keypad columns
    output logic signed [`CALC_WIDTH-1:0] entry_value,
    output logic signed [`CALC_WIDTH-1:0] result,
    output logic                          result_valid,
    output logic                          overflow
);
    import calc_pkg::*;

    logic                          read_input;  // scanner -> controller
    logic                          key_read;    // controller -> scanner
    key_kind_t                     key_kind;
    logic [3:0]                    key_digit;
    op_t                           key_op;
    logic signed [`CALC_WIDTH-1:0] alu_a, alu_b, alu_y;
    op_t                           alu_op;
    logic                          alu_ovf;

    keypad_scan i_scan (
        .clk(clk), .nRST(nRST),
        .row_in(row_in), .col_out(col_out),
        .read_input(read_input), .key_read(key_read),
        .key_kind(key_kind), .key_digit(key_digit), .key_op(key_op)
    );

    calc_control i_ctrl (
        .clk(clk), .nRST(nRST),
        .read_input(read_input), .key_kind(key_kind),
        .key_digit(key_digit), .key_op(key_op), .key_read(key_read),
        .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op),
        .alu_y(alu_y), .alu_ovf(alu_ovf),
        .entry_value(entry_value), .result(result),
        .result_valid(result_valid), .overflow(overflow)
    );

    calc_alu i_alu (
        .a(alu_a), .b(alu_b), .op(alu_op), .y(alu_y), .ovf(alu_ovf)
    );

endmodule

//--- verif/keypad_model.sv
module keypad_model (
    input  logic [3:0] col_out,     // columns from scanner, active low
    input  logic [1:0] press_row,   // row of the key held down
    input  logic [1:0] press_col,   // column of the key held down
    input  logic       pressed,     // key switch closed
    output logic [3:0] row_in       // rows back to scanner
);

    // rows idle high through pull-ups
    // a closed switch shorts its row to its column,
    // so the row only reads low while that column is driven low
    always_comb begin
        row_in = 4'b1111;
        if (pressed && !col_out[press_col])
            row_in[press_row] = 1'b0;
    end

endmodule

//--- verif/tb_calculator.sv
`include "calc_consts.svh"

module tb_calculator;
    import calc_pkg::*;

    localparam int W = `CALC_WIDTH;
    localparam int HOLD = `DEBOUNCE_CYCLES + 20;    // cycles a normal press is held
    localparam logic [3:0] K_ADD = 4'd3;
    localparam logic [3:0] K_SUB = 4'd7;
    localparam logic [3:0] K_MUL = 4'd11;
    localparam logic [3:0] K_EQ  = 4'd12;
    localparam logic [3:0] K_NEG = 4'd15;

    logic                clk;
    logic                nRST;
    logic [3:0]          row_in;
    logic [3:0]          col_out;
    logic signed [W-1:0] entry_value;
    logic signed [W-1:0] result;
    logic                result_valid;
    logic                overflow;
    logic [1:0]          press_row;
    logic [1:0]          press_col;
    logic                pressed;

    logic [15:0]         lfsr;          // random source
    logic signed [W-1:0] m_entry;       // reference model state
    logic signed [W-1:0] m_acc;
    op_t                 m_op;
    logic                m_sticky;
    logic signed [W-1:0] exp_result;    // expected at next result_valid
    logic                exp_ovf;
    int                  checks;
    int                  fails;
    int                  base_checks;
    int                  base_fails;
    int                  test_no;

    calculator_top i_dut (
        .clk(clk), .nRST(nRST), .row_in(row_in), .col_out(col_out),
        .entry_value(entry_value), .result(result),
        .result_valid(result_valid), .overflow(overflow)
    );

    keypad_model i_keypad (
        .col_out(col_out), .press_row(press_row), .press_col(press_col),
        .pressed(pressed), .row_in(row_in)
    );

    always #50 clk = ~clk;

    // result and overflow checked mid-cycle on every pulse
    always @(negedge clk) begin
        if (nRST && result_valid) begin
            checks++;
            assert (result == exp_result && overflow == exp_ovf) else begin
                fails++;
                $display("FAIL %0t: result %0d ovf %0b, expected %0d ovf %0b",
                         $time, result, overflow, exp_result, exp_ovf);
            end
        end
    end

    // taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // exact integer math, then cut to W bits
    function automatic logic signed [W-1:0] alu_ref(input logic signed [W-1:0] a,
                                                    input logic signed [W-1:0] b,
                                                    input op_t op, output logic ovf);
        int exact;
        int lim;
        lim = 1 << (W - 1);
        case (op)
            op_add:  exact = int'(a) + int'(b);
            op_sub:  exact = int'(a) - int'(b);
            op_mul:  exact = int'(a) * int'(b);
            default: exact = int'(b);       // no pending op loads entry
        endcase
        ovf = (exact >= lim) || (exact < -lim);
        return W'(exact);
    endfunction

    function automatic logic [3:0] digit_index(input int d);
        if (d == 0)
            return 4'd13;
        return 4'(((d - 1) / 3) * 4 + (d - 1) % 3);   // 1..9 fill rows 0..2
    endfunction

    task automatic next_digit(output int d);
        logic [3:0] v;
        v = '0;
        repeat (4) begin
            lfsr = lfsr_step(lfsr);
            v = {v[2:0], lfsr[0]};                  // one step per bit
        end
        d = int'(v) % 10;
    endtask

    // calculator rules applied to one accepted key
    task automatic apply_key(input logic [3:0] idx);
        logic ovf;
        logic signed [W-1:0] y;
        y = alu_ref(m_acc, m_entry, m_op, ovf);
        case (idx)
            K_ADD, K_SUB, K_MUL: begin
                m_acc = y;
                m_sticky = m_sticky | ovf;
                m_op = (idx == K_ADD) ? op_add : (idx == K_SUB) ? op_sub : op_mul;
                m_entry = '0;
            end
            K_NEG: m_entry = -m_entry;
            K_EQ: begin
                exp_result = y;
                exp_ovf = m_sticky | ovf;
                m_acc = y;
                m_sticky = 1'b0;
                m_entry = '0;
                m_op = op_none;
            end
            4'd14: ;                                // blank position
            default: m_entry = W'(int'(m_entry) * 10 +
                               ((idx == 4'd13) ? 0 : int'(idx / 4) * 3 + int'(idx % 4) + 1));
        endcase
    endtask

    // hold, release, then check pulse count and entry
    task automatic press_key(input logic [3:0] idx, input int hold, input bit counted);
        int pulses;
        int want;
        pulses = 0;
        want = (counted && idx == K_EQ) ? 1 : 0;
        if (counted)
            apply_key(idx);
        @(posedge clk);
        #10;
        press_row = idx[3:2];
        press_col = idx[1:0];
        pressed = 1'b1;
        for (int i = 0; i < hold + 20; i++) begin  // bounded wait for the pulse
            if (i == hold) begin
                @(posedge clk);
                #10;
                pressed = 1'b0;
            end
            @(negedge clk);
            if (result_valid)
                pulses++;
        end
        checks += 2;
        assert (pulses == want) else begin
            fails++;
            $display("key %0d gave %0d result pulses where %0d were due", idx, pulses, want);
        end
        assert (entry_value == m_entry) else begin
            fails++;
            $display("FAIL %0t: entry %0d after key %0d, expected %0d",
                     $time, entry_value, idx, m_entry);
        end
    endtask

    task automatic type_random(input int ndig);
        int d;
        repeat (ndig) begin
            next_digit(d);
            press_key(digit_index(d), HOLD, 1'b1);
        end
    endtask

    task automatic type_number(input int n);
        int q[$];
        do begin
            q.push_front(n % 10);
            n = n / 10;
        end while (n > 0);
        foreach (q[i])
            press_key(digit_index(q[i]), HOLD, 1'b1);
    endtask

    task automatic start_test();
        base_checks = checks;
        base_fails = fails;
    endtask

    task automatic finish_test(input string name);
        test_no++;
        $display("test %0d %s: %0d checks, %0d failed", test_no, name,
                 checks - base_checks, fails - base_fails);
    endtask

    initial begin
        clk = 1'b0;
        nRST = 1'b0;
        pressed = 1'b0;
        press_row = 2'd0;
        press_col = 2'd0;
        lfsr = 16'd5665;
        m_entry = '0;
        m_acc = '0;
        m_op = op_none;
        m_sticky = 1'b0;
        exp_result = '0;
        exp_ovf = 1'b0;
        checks = 0;
        fails = 0;
        test_no = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        checks++;
        assert (result == 0 && !result_valid && !overflow && entry_value == 0
                && col_out == 4'b1110) else begin
            fails++;
            $display("FAIL %0t: outputs not at reset values", $time);
        end
        #60;
        nRST = 1'b1;

        start_test();
        type_random(4);                             // running decimal on entry
        press_key(K_EQ, HOLD, 1'b1);
        finish_test("digit entry");

        start_test();
        repeat (4) begin
            type_random(3);
            lfsr = lfsr_step(lfsr);
            press_key(lfsr[0] ? K_SUB : K_ADD, HOLD, 1'b1);
            type_random(3);
            press_key(K_EQ, HOLD, 1'b1);
        end
        finish_test("add and subtract");

        start_test();
        type_number(5);
        press_key(K_NEG, HOLD, 1'b1);
        press_key(K_ADD, HOLD, 1'b1);
        type_number(3);
        press_key(K_EQ, HOLD, 1'b1);                // -2
        finish_test("sign key");

        start_test();
        type_number(12);
        press_key(K_MUL, HOLD, 1'b1);
        type_number(11);
        press_key(K_EQ, HOLD, 1'b1);
        type_number(300);
        press_key(K_MUL, HOLD, 1'b1);
        type_number(300);
        press_key(K_EQ, HOLD, 1'b1);                // wraps, ovf set
        type_number(300);
        press_key(K_MUL, HOLD, 1'b1);
        type_number(300);
        press_key(K_ADD, HOLD, 1'b1);               // product overflows on the fold
        type_number(1);
        press_key(K_EQ, HOLD, 1'b1);                // sticky flag reported here
        finish_test("multiply and overflow");

        start_test();
        type_number(2);
        press_key(K_ADD, HOLD, 1'b1);
        type_number(3);
        press_key(K_MUL, HOLD, 1'b1);
        type_number(4);
        press_key(K_EQ, HOLD, 1'b1);                // left to right gives 20
        press_key(K_EQ, HOLD, 1'b1);                // empty entry
        finish_test("chaining");

        start_test();
        press_key(digit_index(8), `DEBOUNCE_CYCLES / 2, 1'b0);  // too short
        press_key(digit_index(7), 200, 1'b1);       // held long, one digit
        press_key(4'd14, HOLD, 1'b1);               // blank position ignored
        press_key(K_EQ, HOLD, 1'b1);
        finish_test("debounce and single read");

        $display("tests %0d, checks %0d, failures %0d", test_no, checks, fails);
        if (fails == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verilog
verilog/calc_pkg.sv
verilog/calc_alu.sv
verilog/keypad_scan.sv
verilog/calc_control.sv
verilog/calculator_top.sv
verif/keypad_model.sv
verif/tb_calculator.sv

//--- Makefile
all: run

compile:
	verilator --binary --assert --timing -Wno-fatal --top-module tb_calculator \
		-f vlog.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_calculator)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
